//--- filelist.f
+incdir+verilog
verilog/iso_ctrl_pkg.sv
verilog/iso_axi_pkg.sv
verilog/iso_pending_cnt.sv
verilog/iso_addr_gate.sv
verilog/iso_write_path.sv
verilog/iso_read_path.sv
verilog/axi_iso_top.sv
verification/axi_iso_sva.sv
verification/tb_axi_iso.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_axi_iso
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, check the log for the pass line"
	@echo "  clean  remove build output and log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "=== PASS ===" $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- verification/tb_axi_iso.sv
//////////////////////////////////////////////////
// Testbench for the AXI4 bus isolator
// Random manager and subordinate models, checks
//////////////////////////////////////////////////

`include "iso_defs.svh"

module tb_axi_iso
  import iso_axi_pkg::*;
();

  timeunit 1ns;
  timeprecision 100ps;

  localparam int NumPhases = 12;
  localparam int WaitLimit = 4000;

  // Clock, reset, isolation control
  logic       clk_i = 1'b0;
  logic       rst_i = 1'b1;
  logic       isolate_i = 1'b0;
  logic       isolated_o;
  // Upstream side
  logic       slv_aw_valid_i = 1'b0;
  logic       slv_aw_ready_o;
  iso_id_t    slv_aw_id_i = '0;
  iso_addr_t  slv_aw_addr_i = '0;
  logic [7:0] slv_aw_len_i = '0;
  logic [2:0] slv_aw_size_i = 3'd2;
  logic [1:0] slv_aw_burst_i = 2'b01;
  logic       slv_w_valid_i = 1'b0;
  logic       slv_w_ready_o;
  iso_data_t  slv_w_data_i = '0;
  iso_strb_t  slv_w_strb_i = '1;
  logic       slv_w_last_i = 1'b0;
  logic       slv_b_valid_o;
  logic       slv_b_ready_i = 1'b0;
  iso_id_t    slv_b_id_o;
  logic [1:0] slv_b_resp_o;
  logic       slv_ar_valid_i = 1'b0;
  logic       slv_ar_ready_o;
  iso_id_t    slv_ar_id_i = '0;
  iso_addr_t  slv_ar_addr_i = '0;
  logic [7:0] slv_ar_len_i = '0;
  logic [2:0] slv_ar_size_i = 3'd2;
  logic [1:0] slv_ar_burst_i = 2'b01;
  logic       slv_r_valid_o;
  logic       slv_r_ready_i = 1'b0;
  iso_id_t    slv_r_id_o;
  iso_data_t  slv_r_data_o;
  logic [1:0] slv_r_resp_o;
  logic       slv_r_last_o;
  // Downstream side
  logic       mst_aw_valid_o;
  logic       mst_aw_ready_i = 1'b0;
  iso_id_t    mst_aw_id_o;
  iso_addr_t  mst_aw_addr_o;
  logic [7:0] mst_aw_len_o;
  logic [2:0] mst_aw_size_o;
  logic [1:0] mst_aw_burst_o;
  logic       mst_w_valid_o;
  logic       mst_w_ready_i = 1'b0;
  iso_data_t  mst_w_data_o;
  iso_strb_t  mst_w_strb_o;
  logic       mst_w_last_o;
  logic       mst_b_valid_i = 1'b0;
  logic       mst_b_ready_o;
  iso_id_t    mst_b_id_i = '0;
  logic [1:0] mst_b_resp_i = '0;
  logic       mst_ar_valid_o;
  logic       mst_ar_ready_i = 1'b0;
  iso_id_t    mst_ar_id_o;
  iso_addr_t  mst_ar_addr_o;
  logic [7:0] mst_ar_len_o;
  logic [2:0] mst_ar_size_o;
  logic [1:0] mst_ar_burst_o;
  logic       mst_r_valid_i = 1'b0;
  logic       mst_r_ready_o;
  iso_id_t    mst_r_id_i = '0;
  iso_data_t  mst_r_data_i = '0;
  logic [1:0] mst_r_resp_i = '0;
  logic       mst_r_last_i = 1'b0;

  //////////////////////////////////////////////////
  // Model state
  //////////////////////////////////////////////////
  integer     seed = 32'h6873_0aa9;
  logic       traffic_en = 1'b0;
  logic       iso_prev = 1'b1;
  // Manager view
  iso_id_t    exp_b_id[$];
  int         w_todo[$];
  int         w_beat = 0;
  iso_addr_t  exp_r_addr[$];
  int         exp_r_len[$];
  int         r_beat = 0;
  int         wr_out = 0;
  int         rd_out = 0;
  // Subordinate view
  iso_id_t    sub_aw_id[$];
  iso_id_t    sub_b_id[$];
  iso_id_t    sub_ar_id[$];
  iso_addr_t  sub_ar_addr[$];
  int         sub_ar_len[$];
  int         sub_r_beat = 0;

  axi_iso_top DUT (.*);

  always #2 clk_i = ~clk_i;

  // True with a chance of quarters out of four
  function automatic bit chance(input int quarters);
    chance = (($random(seed) & 3) < quarters);
  endfunction

  task automatic check_eq(input string what, input logic [63:0] got, input logic [63:0] exp);
    if (got !== exp) begin
      $display("mismatch at %0t ns: %s got 0x%0h expected 0x%0h", $time, what, got, exp);
      $display("=== FAIL ===");
      $fatal(1, "check failed");
    end
  endtask

  //////////////////////////////////////////////////
  // Pass-through and isolation checks
  //////////////////////////////////////////////////
  task automatic check_channels();
    if (!isolated_o) begin
      if (mst_aw_valid_o) begin
        check_eq("aw valid", slv_aw_valid_i, 1'b1);
        check_eq("aw id", mst_aw_id_o, slv_aw_id_i);
        check_eq("aw addr", mst_aw_addr_o, slv_aw_addr_i);
        check_eq("aw len", mst_aw_len_o, slv_aw_len_i);
        check_eq("aw size", mst_aw_size_o, slv_aw_size_i);
        check_eq("aw burst", mst_aw_burst_o, slv_aw_burst_i);
      end
      if (mst_ar_valid_o) begin
        check_eq("ar valid", slv_ar_valid_i, 1'b1);
        check_eq("ar id", mst_ar_id_o, slv_ar_id_i);
        check_eq("ar addr", mst_ar_addr_o, slv_ar_addr_i);
        check_eq("ar len", mst_ar_len_o, slv_ar_len_i);
        check_eq("ar size", mst_ar_size_o, slv_ar_size_i);
        check_eq("ar burst", mst_ar_burst_o, slv_ar_burst_i);
      end
      if (mst_w_valid_o) begin
        check_eq("w valid", slv_w_valid_i, 1'b1);
        check_eq("w data", mst_w_data_o, slv_w_data_i);
        check_eq("w strb", mst_w_strb_o, slv_w_strb_i);
        check_eq("w last", mst_w_last_o, slv_w_last_i);
      end
      if (slv_b_valid_o) begin
        check_eq("b valid", mst_b_valid_i, 1'b1);
        check_eq("b id pass", slv_b_id_o, mst_b_id_i);
        check_eq("b resp pass", slv_b_resp_o, mst_b_resp_i);
      end
      if (slv_r_valid_o) begin
        check_eq("r valid", mst_r_valid_i, 1'b1);
        check_eq("r id pass", slv_r_id_o, mst_r_id_i);
        check_eq("r data pass", slv_r_data_o, mst_r_data_i);
        check_eq("r resp pass", slv_r_resp_o, mst_r_resp_i);
        check_eq("r last pass", slv_r_last_o, mst_r_last_i);
      end
    end else begin
      check_eq("mst valids isolated", {mst_aw_valid_o, mst_w_valid_o, mst_ar_valid_o}, 0);
      check_eq("slv readies isolated", {slv_aw_ready_o, slv_w_ready_o, slv_ar_ready_o}, 0);
      // Isolation only once nothing is open
      if (!iso_prev) begin
        check_eq("open writes at isolation", wr_out, 0);
        check_eq("open reads at isolation", rd_out, 0);
      end
    end
    iso_prev = isolated_o;
    check_eq("writes within capacity", wr_out <= `ISO_NUM_PENDING, 1'b1);
    check_eq("reads within capacity", rd_out <= `ISO_NUM_PENDING, 1'b1);
  endtask

  //////////////////////////////////////////////////
  // Manager model
  //////////////////////////////////////////////////
  task automatic step_manager();
    if (slv_aw_valid_i && slv_aw_ready_o) begin
      exp_b_id.push_back(slv_aw_id_i);
      w_todo.push_back(int'(slv_aw_len_i));
      wr_out++;
      slv_aw_valid_i <= 1'b0;
    end
    if ((!slv_aw_valid_i || slv_aw_ready_o) && traffic_en && chance(1)) begin
      slv_aw_valid_i <= 1'b1;
      slv_aw_id_i    <= iso_id_t'($random(seed));
      slv_aw_addr_i  <= iso_addr_t'($random(seed)) & ~iso_addr_t'(3);
      slv_aw_len_i   <= 8'($random(seed) & 3);
    end
    // W bursts follow their accepted AW in order
    if (slv_w_valid_i && slv_w_ready_o) begin
      if (slv_w_last_i) begin
        w_todo.delete(0);
        w_beat = 0;
      end else begin
        w_beat++;
      end
      slv_w_valid_i <= 1'b0;
    end
    if ((!slv_w_valid_i || slv_w_ready_o) && w_todo.size() > 0 && chance(3)) begin
      slv_w_valid_i <= 1'b1;
      slv_w_data_i  <= iso_data_t'($random(seed));
      slv_w_strb_i  <= iso_strb_t'($random(seed));
      slv_w_last_i  <= (w_beat == w_todo[0]);
    end
    if (slv_b_valid_o && slv_b_ready_i) begin
      check_eq("b expected", exp_b_id.size() > 0, 1'b1);
      check_eq("b id", slv_b_id_o, exp_b_id[0]);
      check_eq("b resp", slv_b_resp_o, 2'b00);
      exp_b_id.delete(0);
      wr_out--;
    end
    slv_b_ready_i <= chance(3);
    if (slv_ar_valid_i && slv_ar_ready_o) begin
      exp_r_addr.push_back(slv_ar_addr_i);
      exp_r_len.push_back(int'(slv_ar_len_i));
      rd_out++;
      slv_ar_valid_i <= 1'b0;
    end
    if ((!slv_ar_valid_i || slv_ar_ready_o) && traffic_en && chance(1)) begin
      slv_ar_valid_i <= 1'b1;
      slv_ar_id_i    <= iso_id_t'($random(seed));
      slv_ar_addr_i  <= iso_addr_t'($random(seed)) & ~iso_addr_t'(3);
      slv_ar_len_i   <= 8'($random(seed) & 3);
    end
    // R data is address plus beat index
    if (slv_r_valid_o && slv_r_ready_i) begin
      check_eq("r expected", exp_r_addr.size() > 0, 1'b1);
      check_eq("r data", slv_r_data_o, iso_data_t'(exp_r_addr[0] + r_beat));
      check_eq("r last", slv_r_last_o, r_beat == exp_r_len[0]);
      if (r_beat == exp_r_len[0]) begin
        exp_r_addr.delete(0);
        exp_r_len.delete(0);
        r_beat = 0;
        rd_out--;
      end else begin
        r_beat++;
      end
    end
    slv_r_ready_i <= chance(3);
  endtask

  //////////////////////////////////////////////////
  // Subordinate model
  //////////////////////////////////////////////////
  task automatic step_subordinate();
    iso_id_t   id;
    if (mst_aw_valid_o && mst_aw_ready_i) begin
      sub_aw_id.push_back(mst_aw_id_o);
    end
    mst_aw_ready_i <= chance(2);
    // B answers with the ID of the oldest AW
    if (mst_w_valid_o && mst_w_ready_i && mst_w_last_o) begin
      id = sub_aw_id.pop_front();
      sub_b_id.push_back(id);
    end
    mst_w_ready_i <= chance(3);
    if (mst_b_valid_i && mst_b_ready_o) begin
      sub_b_id.delete(0);
      mst_b_valid_i <= 1'b0;
    end
    if ((!mst_b_valid_i || mst_b_ready_o) && sub_b_id.size() > 0 && chance(2)) begin
      mst_b_valid_i <= 1'b1;
      mst_b_id_i    <= sub_b_id[0];
    end
    if (mst_ar_valid_o && mst_ar_ready_i) begin
      sub_ar_id.push_back(mst_ar_id_o);
      sub_ar_addr.push_back(mst_ar_addr_o);
      sub_ar_len.push_back(int'(mst_ar_len_o));
    end
    mst_ar_ready_i <= chance(2);
    if (mst_r_valid_i && mst_r_ready_o) begin
      if (mst_r_last_i) begin
        sub_ar_id.delete(0);
        sub_ar_addr.delete(0);
        sub_ar_len.delete(0);
        sub_r_beat = 0;
      end else begin
        sub_r_beat++;
      end
      mst_r_valid_i <= 1'b0;
    end
    if ((!mst_r_valid_i || mst_r_ready_o) && sub_ar_addr.size() > 0 && chance(2)) begin
      mst_r_valid_i <= 1'b1;
      mst_r_id_i    <= sub_ar_id[0];
      mst_r_data_i  <= iso_data_t'(sub_ar_addr[0] + sub_r_beat);
      mst_r_resp_i  <= 2'($random(seed));
      mst_r_last_i  <= (sub_r_beat == sub_ar_len[0]);
    end
  endtask

  always @(posedge clk_i) begin
    if (!rst_i) begin
      check_channels();
      step_manager();
      step_subordinate();
    end
  end

  task automatic wait_isolated(input logic level);
    int n;
    n = 0;
    while (isolated_o !== level) begin
      @(posedge clk_i);
      n++;
      if (n > WaitLimit) begin
        $display("isolated_o did not reach %0b in time", level);
        $display("=== FAIL ===");
        $fatal(1, "isolation timeout");
      end
    end
  endtask

  task automatic wait_drained();
    int n;
    n = 0;
    while (exp_b_id.size() != 0 || exp_r_addr.size() != 0 || w_todo.size() != 0 ||
           slv_aw_valid_i || slv_ar_valid_i) begin
      @(posedge clk_i);
      n++;
      if (n > WaitLimit) begin
        $display("outstanding traffic did not complete in time");
        $display("=== FAIL ===");
        $fatal(1, "drain timeout");
      end
    end
  endtask

  //////////////////////////////////////////////////
  // Test sequence
  //////////////////////////////////////////////////
  initial begin
    repeat (16) @(posedge clk_i);
    rst_i <= 1'b0;
    wait_isolated(1'b0);
    traffic_en <= 1'b1;
    // Isolate at random points under live traffic
    for (int p = 0; p < NumPhases; p++) begin
      repeat (20 + ($random(seed) & 127)) @(posedge clk_i);
      isolate_i <= 1'b1;
      @(posedge clk_i);
      wait_isolated(1'b1);
      repeat (4 + ($random(seed) & 31)) @(posedge clk_i);
      isolate_i <= 1'b0;
      @(posedge clk_i);
      wait_isolated(1'b0);
    end
    traffic_en <= 1'b0;
    @(posedge clk_i);
    wait_drained();
    repeat (8) @(posedge clk_i);
    check_eq("sub aw queue empty", sub_aw_id.size(), 0);
    check_eq("sub b queue empty", sub_b_id.size(), 0);
    check_eq("sub ar queue empty", sub_ar_addr.size(), 0);
    check_eq("open writes at end", wr_out, 0);
    check_eq("open reads at end", rd_out, 0);
    $display("=== PASS ===");
    $finish;
  end

endmodule

//--- verification/axi_iso_sva.sv
//////////////////////////////////////////////////
// Bound assertions for the AXI isolator
// Counter range and quiet outputs when isolated
//////////////////////////////////////////////////

`include "iso_defs.svh"

module axi_iso_sva import iso_ctrl_pkg::*; (
  input logic       clk_i,
  input logic       rst_i,
  input logic       inc_i,
  input logic       dec_i,
  input iso_cnt_t   cnt_i,
  input logic       isolated_i,
  input logic [2:0] mst_valid_i
);

  timeunit 1ns;
  timeprecision 100ps;

  // Count never goes above capacity
  a_cnt_in_range: assert property (@(posedge clk_i) disable iff (rst_i)
    cnt_i <= iso_cnt_t'(`ISO_NUM_PENDING))
    else $error("outstanding count above capacity");

  // No increment once full
  a_no_overflow: assert property (@(posedge clk_i) disable iff (rst_i)
    (inc_i && !dec_i) |-> (cnt_i < iso_cnt_t'(`ISO_NUM_PENDING)))
    else $error("outstanding count incremented at capacity");

  // No decrement at zero
  a_no_underflow: assert property (@(posedge clk_i) disable iff (rst_i)
    (dec_i && !inc_i) |-> (cnt_i != '0))
    else $error("outstanding count decremented at zero");

  // AW, W and AR toward the subordinate stay quiet
  a_isolated_quiet: assert property (@(posedge clk_i) disable iff (rst_i)
    isolated_i |-> (mst_valid_i == 3'b000))
    else $error("downstream valid raised while isolated");

endmodule

// Counter instances see only the range checks
bind iso_pending_cnt axi_iso_sva u_cnt_sva (
  .clk_i       (clk_i),
  .rst_i       (rst_i),
  .inc_i       (inc_i),
  .dec_i       (dec_i),
  .cnt_i       (cnt_o),
  .isolated_i  (1'b0),
  .mst_valid_i (3'b000)
);

// Top level sees only the isolation check
bind axi_iso_top axi_iso_sva u_top_sva (
  .clk_i       (clk_i),
  .rst_i       (rst_i),
  .inc_i       (1'b0),
  .dec_i       (1'b0),
  .cnt_i       ({`ISO_CNT_W{1'b0}}),
  .isolated_i  (isolated_o),
  .mst_valid_i ({mst_aw_valid_o, mst_w_valid_o, mst_ar_valid_o})
);

//--- verilog/axi_iso_top.sv
//////////////////////////////////////////////////
// AXI4 bus isolator top level
// Joins write and read directions
//////////////////////////////////////////////////

module axi_iso_top import iso_axi_pkg::*; (
  input  logic       clk_i,
  input  logic       rst_i,
  input  logic       isolate_i,
  output logic       isolated_o,
  //////////////////////////////////////////////////
  // Upstream side, toward the manager
  //////////////////////////////////////////////////
  input  logic       slv_aw_valid_i,
  output logic       slv_aw_ready_o,
  input  iso_id_t    slv_aw_id_i,
  input  iso_addr_t  slv_aw_addr_i,
  input  logic [7:0] slv_aw_len_i,
  input  logic [2:0] slv_aw_size_i,
  input  logic [1:0] slv_aw_burst_i,
  input  logic       slv_w_valid_i,
  output logic       slv_w_ready_o,
  input  iso_data_t  slv_w_data_i,
  input  iso_strb_t  slv_w_strb_i,
  input  logic       slv_w_last_i,
  output logic       slv_b_valid_o,
  input  logic       slv_b_ready_i,
  output iso_id_t    slv_b_id_o,
  output logic [1:0] slv_b_resp_o,
  input  logic       slv_ar_valid_i,
  output logic       slv_ar_ready_o,
  input  iso_id_t    slv_ar_id_i,
  input  iso_addr_t  slv_ar_addr_i,
  input  logic [7:0] slv_ar_len_i,
  input  logic [2:0] slv_ar_size_i,
  input  logic [1:0] slv_ar_burst_i,
  output logic       slv_r_valid_o,
  input  logic       slv_r_ready_i,
  output iso_id_t    slv_r_id_o,
  output iso_data_t  slv_r_data_o,
  output logic [1:0] slv_r_resp_o,
  output logic       slv_r_last_o,
  //////////////////////////////////////////////////
  // Downstream side, toward the subordinate
  //////////////////////////////////////////////////
  output logic       mst_aw_valid_o,
  input  logic       mst_aw_ready_i,
  output iso_id_t    mst_aw_id_o,
  output iso_addr_t  mst_aw_addr_o,
  output logic [7:0] mst_aw_len_o,
  output logic [2:0] mst_aw_size_o,
  output logic [1:0] mst_aw_burst_o,
  output logic       mst_w_valid_o,
  input  logic       mst_w_ready_i,
  output iso_data_t  mst_w_data_o,
  output iso_strb_t  mst_w_strb_o,
  output logic       mst_w_last_o,
  input  logic       mst_b_valid_i,
  output logic       mst_b_ready_o,
  input  iso_id_t    mst_b_id_i,
  input  logic [1:0] mst_b_resp_i,
  output logic       mst_ar_valid_o,
  input  logic       mst_ar_ready_i,
  output iso_id_t    mst_ar_id_o,
  output iso_addr_t  mst_ar_addr_o,
  output logic [7:0] mst_ar_len_o,
  output logic [2:0] mst_ar_size_o,
  output logic [1:0] mst_ar_burst_o,
  input  logic       mst_r_valid_i,
  output logic       mst_r_ready_o,
  input  iso_id_t    mst_r_id_i,
  input  iso_data_t  mst_r_data_i,
  input  logic [1:0] mst_r_resp_i,
  input  logic       mst_r_last_i
);

  logic wr_isolated;
  logic rd_isolated;

  // Port names match the top level one to one
  iso_write_path u_write_path (
    .isolated_o (wr_isolated),
    .*
  );

  iso_read_path u_read_path (
    .isolated_o (rd_isolated),
    .*
  );

  // Isolated only once both directions are
  assign isolated_o = wr_isolated && rd_isolated;

endmodule

//--- verilog/iso_read_path.sv
//////////////////////////////////////////////////
// Read direction of the AXI isolator
// AR gate and outstanding read counter
//////////////////////////////////////////////////

`include "iso_defs.svh"

module iso_read_path import iso_axi_pkg::*; (
  input  logic       clk_i,
  input  logic       rst_i,
  input  logic       isolate_i,
  // Upstream AR and R
  input  logic       slv_ar_valid_i,
  output logic       slv_ar_ready_o,
  input  iso_id_t    slv_ar_id_i,
  input  iso_addr_t  slv_ar_addr_i,
  input  logic [7:0] slv_ar_len_i,
  input  logic [2:0] slv_ar_size_i,
  input  logic [1:0] slv_ar_burst_i,
  output logic       slv_r_valid_o,
  input  logic       slv_r_ready_i,
  output iso_id_t    slv_r_id_o,
  output iso_data_t  slv_r_data_o,
  output logic [1:0] slv_r_resp_o,
  output logic       slv_r_last_o,
  // Downstream AR and R
  output logic       mst_ar_valid_o,
  input  logic       mst_ar_ready_i,
  output iso_id_t    mst_ar_id_o,
  output iso_addr_t  mst_ar_addr_o,
  output logic [7:0] mst_ar_len_o,
  output logic [2:0] mst_ar_size_o,
  output logic [1:0] mst_ar_burst_o,
  input  logic       mst_r_valid_i,
  output logic       mst_r_ready_o,
  input  iso_id_t    mst_r_id_i,
  input  iso_data_t  mst_r_data_i,
  input  logic [1:0] mst_r_resp_i,
  input  logic       mst_r_last_i,
  output logic       isolated_o
);

  ar_chan_t slv_ar;
  ar_chan_t mst_ar;
  r_chan_t  mst_r;
  r_chan_t  slv_r;
  logic     ar_fire;
  logic     r_done;
  logic     rd_full;
  logic     rd_empty;

  assign slv_ar = '{id: slv_ar_id_i, addr: slv_ar_addr_i, len: slv_ar_len_i,
                    size: slv_ar_size_i, burst: slv_ar_burst_i};

  // A read is done on its last R beat
  iso_addr_gate #(
    .payload_t   (ar_chan_t),
    .CountOnLast (1'b1)
  ) u_ar_gate (
    .clk_i            (clk_i),
    .rst_i            (rst_i),
    .isolate_i        (isolate_i),
    .cap_full_i       (rd_full),
    .idle_i           (rd_empty),
    .slv_a_valid_i    (slv_ar_valid_i),
    .slv_a_i          (slv_ar),
    .slv_a_ready_o    (slv_ar_ready_o),
    .mst_a_valid_o    (mst_ar_valid_o),
    .mst_a_o          (mst_ar),
    .mst_a_ready_i    (mst_ar_ready_i),
    .mst_resp_valid_i (mst_r_valid_i),
    .mst_resp_last_i  (mst_r_last_i),
    .mst_resp_ready_o (mst_r_ready_o),
    .slv_resp_valid_o (slv_r_valid_o),
    .slv_resp_ready_i (slv_r_ready_i),
    .a_fire_o         (ar_fire),
    .resp_done_o      (r_done),
    .isolated_o       (isolated_o)
  );

  assign mst_ar_id_o    = mst_ar.id;
  assign mst_ar_addr_o  = mst_ar.addr;
  assign mst_ar_len_o   = mst_ar.len;
  assign mst_ar_size_o  = mst_ar.size;
  assign mst_ar_burst_o = mst_ar.burst;

  iso_pending_cnt #(
    .Cap (`ISO_NUM_PENDING)
  ) u_rd_cnt (
    .clk_i   (clk_i),
    .rst_i   (rst_i),
    .inc_i   (ar_fire),
    .dec_i   (r_done),
    .cnt_o   (),
    .full_o  (rd_full),
    .empty_o (rd_empty)
  );

  // R payload is zero while isolated
  assign mst_r = '{id: mst_r_id_i, data: mst_r_data_i, resp: mst_r_resp_i,
                   last: mst_r_last_i};
  assign slv_r        = isolated_o ? '0 : mst_r;
  assign slv_r_id_o   = slv_r.id;
  assign slv_r_data_o = slv_r.data;
  assign slv_r_resp_o = slv_r.resp;
  assign slv_r_last_o = slv_r.last;

endmodule

//--- verilog/iso_write_path.sv
//////////////////////////////////////////////////
// Write direction of the AXI isolator
// AW gate, AW and W counters, W channel gating
//////////////////////////////////////////////////

`include "iso_defs.svh"

module iso_write_path import iso_axi_pkg::*; (
  input  logic       clk_i,
  input  logic       rst_i,
  input  logic       isolate_i,
  // Upstream AW and W
  input  logic       slv_aw_valid_i,
  output logic       slv_aw_ready_o,
  input  iso_id_t    slv_aw_id_i,
  input  iso_addr_t  slv_aw_addr_i,
  input  logic [7:0] slv_aw_len_i,
  input  logic [2:0] slv_aw_size_i,
  input  logic [1:0] slv_aw_burst_i,
  input  logic       slv_w_valid_i,
  output logic       slv_w_ready_o,
  input  iso_data_t  slv_w_data_i,
  input  iso_strb_t  slv_w_strb_i,
  input  logic       slv_w_last_i,
  // Upstream B
  output logic       slv_b_valid_o,
  input  logic       slv_b_ready_i,
  output iso_id_t    slv_b_id_o,
  output logic [1:0] slv_b_resp_o,
  // Downstream AW and W
  output logic       mst_aw_valid_o,
  input  logic       mst_aw_ready_i,
  output iso_id_t    mst_aw_id_o,
  output iso_addr_t  mst_aw_addr_o,
  output logic [7:0] mst_aw_len_o,
  output logic [2:0] mst_aw_size_o,
  output logic [1:0] mst_aw_burst_o,
  output logic       mst_w_valid_o,
  input  logic       mst_w_ready_i,
  output iso_data_t  mst_w_data_o,
  output iso_strb_t  mst_w_strb_o,
  output logic       mst_w_last_o,
  // Downstream B
  input  logic       mst_b_valid_i,
  output logic       mst_b_ready_o,
  input  iso_id_t    mst_b_id_i,
  input  logic [1:0] mst_b_resp_i,
  output logic       isolated_o
);

  aw_chan_t slv_aw;
  aw_chan_t mst_aw;
  w_chan_t  slv_w;
  w_chan_t  mst_w;
  b_chan_t  mst_b;
  b_chan_t  slv_b;
  logic     aw_fire;
  logic     b_done;
  logic     w_open;
  logic     w_last_fire;
  logic     wr_full;
  logic     wr_empty;
  logic     w_full;
  logic     w_empty;

  assign slv_aw = '{id: slv_aw_id_i, addr: slv_aw_addr_i, len: slv_aw_len_i,
                    size: slv_aw_size_i, burst: slv_aw_burst_i};

  // AW blocks when either count is at capacity
  iso_addr_gate #(
    .payload_t   (aw_chan_t),
    .CountOnLast (1'b0)
  ) u_aw_gate (
    .clk_i            (clk_i),
    .rst_i            (rst_i),
    .isolate_i        (isolate_i),
    .cap_full_i       (wr_full || w_full),
    .idle_i           (wr_empty && w_empty),
    .slv_a_valid_i    (slv_aw_valid_i),
    .slv_a_i          (slv_aw),
    .slv_a_ready_o    (slv_aw_ready_o),
    .mst_a_valid_o    (mst_aw_valid_o),
    .mst_a_o          (mst_aw),
    .mst_a_ready_i    (mst_aw_ready_i),
    .mst_resp_valid_i (mst_b_valid_i),
    .mst_resp_last_i  (),
    .mst_resp_ready_o (mst_b_ready_o),
    .slv_resp_valid_o (slv_b_valid_o),
    .slv_resp_ready_i (slv_b_ready_i),
    .a_fire_o         (aw_fire),
    .resp_done_o      (b_done),
    .isolated_o       (isolated_o)
  );

  assign mst_aw_id_o    = mst_aw.id;
  assign mst_aw_addr_o  = mst_aw.addr;
  assign mst_aw_len_o   = mst_aw.len;
  assign mst_aw_size_o  = mst_aw.size;
  assign mst_aw_burst_o = mst_aw.burst;

  // Open write bursts, closed by B
  iso_pending_cnt #(
    .Cap (`ISO_NUM_PENDING)
  ) u_wr_cnt (
    .clk_i   (clk_i),
    .rst_i   (rst_i),
    .inc_i   (aw_fire),
    .dec_i   (b_done),
    .cnt_o   (),
    .full_o  (wr_full),
    .empty_o (wr_empty)
  );

  // Open W bursts, closed by the last beat
  iso_pending_cnt #(
    .Cap (`ISO_NUM_PENDING)
  ) u_w_cnt (
    .clk_i   (clk_i),
    .rst_i   (rst_i),
    .inc_i   (aw_fire),
    .dec_i   (w_last_fire),
    .cnt_o   (),
    .full_o  (w_full),
    .empty_o (w_empty)
  );

  //////////////////////////////////////////////////
  // W gating
  //////////////////////////////////////////////////
  // W only flows once its AW has gone downstream
  assign w_open        = !w_empty || aw_fire;
  assign slv_w         = '{data: slv_w_data_i, strb: slv_w_strb_i, last: slv_w_last_i};
  assign mst_w         = w_open ? slv_w : '0;
  assign mst_w_valid_o = w_open && slv_w_valid_i;
  assign slv_w_ready_o = w_open && mst_w_ready_i;
  assign w_last_fire   = mst_w_valid_o && mst_w_ready_i && mst_w.last;
  assign mst_w_data_o  = mst_w.data;
  assign mst_w_strb_o  = mst_w.strb;
  assign mst_w_last_o  = mst_w.last;

  // B payload is zero while isolated
  assign mst_b        = '{id: mst_b_id_i, resp: mst_b_resp_i};
  assign slv_b        = isolated_o ? '0 : mst_b;
  assign slv_b_id_o   = slv_b.id;
  assign slv_b_resp_o = slv_b.resp;

endmodule

//--- verilog/iso_addr_gate.sv
//////////////////////////////////////////////////
// Isolation controller for one AXI direction
// Gates an address channel and its response
// handshake through Normal, Hold, Drain, Isolate
//////////////////////////////////////////////////

module iso_addr_gate import iso_ctrl_pkg::*; #(
  parameter type payload_t   = logic,
  parameter bit  CountOnLast = 1'b0
) (
  input  logic     clk_i,
  input  logic     rst_i,
  input  logic     isolate_i,
  input  logic     cap_full_i,
  input  logic     idle_i,
  input  logic     slv_a_valid_i,
  input  payload_t slv_a_i,
  output logic     slv_a_ready_o,
  output logic     mst_a_valid_o,
  output payload_t mst_a_o,
  input  logic     mst_a_ready_i,
  input  logic     mst_resp_valid_i,
  input  logic     mst_resp_last_i,
  output logic     mst_resp_ready_o,
  output logic     slv_resp_valid_o,
  input  logic     slv_resp_ready_i,
  output logic     a_fire_o,
  output logic     resp_done_o,
  output logic     isolated_o
);

  iso_state_e state_q;
  iso_state_e state_d;
  logic       resp_fire;

  // Start isolated out of reset
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q <= ISO_ISOLATE;
    end else begin
      state_q <= state_d;
    end
  end

  //////////////////////////////////////////////////
  // State machine and channel gating
  //////////////////////////////////////////////////
  always_comb begin
    // Pass-through by default
    state_d          = state_q;
    mst_a_valid_o    = slv_a_valid_i;
    mst_a_o          = slv_a_i;
    slv_a_ready_o    = mst_a_ready_i;
    slv_resp_valid_o = mst_resp_valid_i;
    mst_resp_ready_o = slv_resp_ready_i;
    case (state_q)
      ISO_NORMAL: begin
        if (cap_full_i) begin
          // Cut both sides of the handshake at capacity
          mst_a_valid_o = 1'b0;
          slv_a_ready_o = 1'b0;
          if (isolate_i) begin
            state_d = ISO_DRAIN;
          end
        end else if (slv_a_valid_i && !mst_a_ready_i) begin
          // Not accepted yet, keep it valid next cycle
          state_d = ISO_HOLD;
        end else if (isolate_i) begin
          state_d = ISO_DRAIN;
        end
      end
      ISO_HOLD: begin
        // Valid toward the subordinate may not drop
        mst_a_valid_o = 1'b1;
        if (mst_a_ready_i) begin
          state_d = isolate_i ? ISO_DRAIN : ISO_NORMAL;
        end
      end
      ISO_DRAIN: begin
        // No new addresses, responses still flow
        mst_a_valid_o = 1'b0;
        mst_a_o       = '0;
        slv_a_ready_o = 1'b0;
        if (idle_i) begin
          state_d = ISO_ISOLATE;
        end
      end
      ISO_ISOLATE: begin
        // Everything silenced, upstream stalls
        mst_a_valid_o    = 1'b0;
        mst_a_o          = '0;
        slv_a_ready_o    = 1'b0;
        slv_resp_valid_o = 1'b0;
        mst_resp_ready_o = 1'b0;
        if (!isolate_i) begin
          state_d = ISO_NORMAL;
        end
      end
      default: begin
        state_d = ISO_ISOLATE;
      end
    endcase
  end

  // Counter pulses, address only transfers in Normal or Hold
  assign a_fire_o  = mst_a_valid_o && mst_a_ready_i;
  assign resp_fire = mst_resp_valid_i && mst_resp_ready_o;

  // Reads finish on the last beat, writes on the single B
  if (CountOnLast) begin : g_count_last
    assign resp_done_o = resp_fire && mst_resp_last_i;
  end else begin : g_count_beat
    assign resp_done_o = resp_fire;
  end

  assign isolated_o = (state_q == ISO_ISOLATE);

endmodule

//--- verilog/iso_pending_cnt.sv
//////////////////////////////////////////////////
// Outstanding transaction counter
// Flags full at capacity and empty at zero
//////////////////////////////////////////////////

`include "iso_defs.svh"

module iso_pending_cnt import iso_ctrl_pkg::*; #(
  parameter int unsigned Cap = `ISO_NUM_PENDING
) (
  input  logic     clk_i,
  input  logic     rst_i,
  input  logic     inc_i,
  input  logic     dec_i,
  output iso_cnt_t cnt_o,
  output logic     full_o,
  output logic     empty_o
);

  iso_cnt_t cnt_q;

  // Simultaneous inc and dec cancel out
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      cnt_q <= '0;
    end else if (inc_i && !dec_i) begin
      cnt_q <= cnt_q + iso_cnt_t'(1);
    end else if (dec_i && !inc_i) begin
      cnt_q <= cnt_q - iso_cnt_t'(1);
    end
  end

  assign cnt_o   = cnt_q;
  // Capacity reached, no new address may pass
  assign full_o  = (cnt_q >= iso_cnt_t'(Cap));
  assign empty_o = (cnt_q == '0);

endmodule

//--- verilog/iso_axi_pkg.sv
//////////////////////////////////////////////////
// AXI channel payload types of the isolator
//////////////////////////////////////////////////

`include "iso_defs.svh"

package iso_axi_pkg;

  // Basic field types
  typedef logic [`ISO_ID_W-1:0]     iso_id_t;
  typedef logic [`ISO_ADDR_W-1:0]   iso_addr_t;
  typedef logic [`ISO_DATA_W-1:0]   iso_data_t;
  typedef logic [`ISO_DATA_W/8-1:0] iso_strb_t;

  // Write address
  typedef struct packed {
    iso_id_t    id;
    iso_addr_t  addr;
    logic [7:0] len;
    logic [2:0] size;
    logic [1:0] burst;
  } aw_chan_t;

  // Read address, same layout as AW
  typedef struct packed {
    iso_id_t    id;
    iso_addr_t  addr;
    logic [7:0] len;
    logic [2:0] size;
    logic [1:0] burst;
  } ar_chan_t;

  // Write data beat
  typedef struct packed {
    iso_data_t data;
    iso_strb_t strb;
    logic      last;
  } w_chan_t;

  // Write response
  typedef struct packed {
    iso_id_t    id;
    logic [1:0] resp;
  } b_chan_t;

  // Read data beat
  typedef struct packed {
    iso_id_t    id;
    iso_data_t  data;
    logic [1:0] resp;
    logic       last;
  } r_chan_t;

endpackage

//--- verilog/iso_ctrl_pkg.sv
//////////////////////////////////////////////////
// Isolation controller states and counter type
//////////////////////////////////////////////////

`include "iso_defs.svh"

package iso_ctrl_pkg;

  // Per-direction controller states
  typedef enum logic [1:0] {
    ISO_NORMAL,
    ISO_HOLD,
    ISO_DRAIN,
    ISO_ISOLATE
  } iso_state_e;

  // Outstanding transaction count
  typedef logic [`ISO_CNT_W-1:0] iso_cnt_t;

endpackage

//--- verilog/iso_defs.svh
//////////////////////////////////////////////////
// AXI isolator widths and capacities
// Shared by both packages and the counters
//////////////////////////////////////////////////

`ifndef ISO_DEFS_SVH
`define ISO_DEFS_SVH

// AXI ID width
`define ISO_ID_W 4

// Address and data widths
`define ISO_ADDR_W 32
`define ISO_DATA_W 32

// Open transactions allowed per counter
`define ISO_NUM_PENDING 4

// Enough bits for 0..NUM_PENDING
// plus one guard bit against wrap
`define ISO_CNT_W 4

`endif
